//--- src/core_pkg.sv
package core_pkg;

  localparam int xlen = 64;
  localparam logic [xlen-1:0] pc_start = 64'h0;

  // bus size codes
  localparam logic [1:0] size_word = 2'd2;
  localparam logic [1:0] size_double = 2'd3;

  // major opcodes
  localparam logic [6:0] op_op = 7'h33;
  localparam logic [6:0] op_imm = 7'h13;
  localparam logic [6:0] op_lui = 7'h37;
  localparam logic [6:0] op_load = 7'h03;
  localparam logic [6:0] op_store = 7'h23;
  localparam logic [6:0] op_branch = 7'h63;
  localparam logic [6:0] op_trap = 7'h6b;

  // halt causes other than the trap instruction
  localparam logic [7:0] halt_illegal = 8'hff;
  localparam logic [7:0] halt_bus_error = 8'hfe;

  typedef struct packed {
    logic [xlen-1:0] pc;
    logic [31:0] inst;
  } fetch_t;

  typedef enum logic [2:0] {
    alu_add,
    alu_sub,
    alu_pass_b,
    alu_beq,
    alu_bne
  } alu_op_t;

  typedef struct packed {
    logic [xlen-1:0] pc;
    alu_op_t alu_op;
    logic [xlen-1:0] a;
    logic [xlen-1:0] b;
    logic [xlen-1:0] store_data;
    logic [4:0] rd;
    logic we;
    logic load;
    logic store;
    logic trap;
    logic illegal;
    logic [xlen-1:0] branch_off;
  } decoded_t;

  typedef struct packed {
    logic [xlen-1:0] result;
    logic [xlen-1:0] store_data;
    logic [4:0] rd;
    logic we;
    logic load;
    logic store;
    logic trap;
    logic illegal;
  } exec_t;

endpackage

//--- src/reg_port_if.sv
`timescale 1ns/1ps

interface reg_port_if;
  import core_pkg::*;

  logic [4:0] rs1_addr;
  logic [4:0] rs2_addr;
  logic [xlen-1:0] rs1_data;
  logic [xlen-1:0] rs2_data;
  logic wr_en;
  logic [4:0] wr_addr;
  logic [xlen-1:0] wr_data;

  // decode also watches the write port to retire scoreboard bits
  modport decode (output rs1_addr, rs2_addr, input rs1_data, rs2_data, wr_en, wr_addr);
  modport writeback (output wr_en, wr_addr, wr_data);
  modport file (input rs1_addr, rs2_addr, wr_en, wr_addr, wr_data, output rs1_data, rs2_data);

endinterface

//--- src/pipe_reg.sv
`timescale 1ns/1ps

module pipe_reg #(
  parameter type payload_t = logic
) (
  input  logic     clock,
  input  logic     reset,
  input  logic     flush,
  input  logic     in_valid,
  output logic     in_ready,
  input  payload_t in_data,
  output logic     out_valid,
  input  logic     out_ready,
  output payload_t out_data
);

  // take new data when empty or when draining this cycle
  assign in_ready = !out_valid || out_ready;

  always_ff @(posedge clock) begin
    if (reset || flush) begin
      out_valid <= 1'b0;
    end else if (in_ready) begin
      out_valid <= in_valid;
    end
  end

  always_ff @(posedge clock) begin
    if (in_valid && in_ready) begin
      out_data <= in_data;
    end
  end

  a_hold_data: assert property (@(posedge clock) disable iff (reset)
    out_valid && !out_ready |=> $stable(out_data));

endmodule

//--- src/fetch_unit.sv
`timescale 1ns/1ps

module fetch_unit (
  input  logic                    clock,
  input  logic                    reset,
  output logic                    if_rw_valid,
  input  logic                    if_rw_ready,
  input  logic [core_pkg::xlen-1:0] if_r_data,
  output logic [core_pkg::xlen-1:0] if_rw_addr,
  output logic [1:0]              if_rw_size,
  input  logic [1:0]              if_rw_resp,
  input  logic                    redirect,
  input  logic [core_pkg::xlen-1:0] redirect_pc,
  input  logic                    halted,
  output logic                    out_valid,
  input  logic                    out_ready,
  output core_pkg::fetch_t        out_data
);
  import core_pkg::*;

  logic req_active;
  logic discard;
  logic buf_valid;
  logic [xlen-1:0] pc;
  logic [xlen-1:0] req_addr;
  logic [31:0] word;
  fetch_t buf_q;

  assign if_rw_valid = req_active;
  assign if_rw_addr = req_addr;
  assign if_rw_size = size_word;
  assign out_valid = buf_valid;
  assign out_data = buf_q;

  // a failed fetch becomes an all-zero word, which decodes as illegal
  assign word = (if_rw_resp != 2'b00) ? 32'h0 :
                req_addr[2] ? if_r_data[63:32] : if_r_data[31:0];

  always_ff @(posedge clock) begin
    if (reset) begin
      pc <= pc_start;
      req_active <= 1'b0;
      discard <= 1'b0;
      buf_valid <= 1'b0;
    end else begin
      if (req_active && if_rw_ready) begin
        req_active <= 1'b0;
        discard <= 1'b0;
        if (!discard && !redirect) begin
          buf_valid <= 1'b1;
          buf_q <= '{pc: req_addr, inst: word};
        end
      end else if (req_active && redirect) begin
        // still owe the bus a completion, drop it when it comes
        discard <= 1'b1;
      end
      if (out_valid && out_ready) begin
        buf_valid <= 1'b0;
        pc <= pc + 64'd4;
      end
      if (redirect) begin
        buf_valid <= 1'b0;
        pc <= redirect_pc;
      end
      if (!req_active && !buf_valid && !halted && !redirect) begin
        req_active <= 1'b1;
        req_addr <= pc;
      end
    end
  end

  a_addr_stable: assert property (@(posedge clock) disable iff (reset)
    if_rw_valid && !if_rw_ready |=> if_rw_valid && $stable(if_rw_addr));

endmodule

//--- src/decode_unit.sv
`timescale 1ns/1ps

module decode_unit (
  input  logic               clock,
  input  logic               reset,
  input  logic               flush,
  input  logic               in_valid,
  output logic               in_ready,
  input  core_pkg::fetch_t   in_data,
  output logic               out_valid,
  input  logic               out_ready,
  output core_pkg::decoded_t out_data,
  reg_port_if.decode         regs
);
  import core_pkg::*;

  logic [31:0] inst;
  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [4:0] rd;
  logic [xlen-1:0] imm_i;
  logic [xlen-1:0] imm_s;
  logic [xlen-1:0] imm_b;
  logic [xlen-1:0] imm_u;
  logic use_rs1;
  logic use_rs2;
  logic stall;
  logic [31:0] pending;
  decoded_t d;

  assign inst = in_data.inst;
  assign opcode = inst[6:0];
  assign funct3 = inst[14:12];
  assign rd = inst[11:7];

  assign imm_i = {{52{inst[31]}}, inst[31:20]};
  assign imm_s = {{52{inst[31]}}, inst[31:25], inst[11:7]};
  assign imm_b = {{51{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
  assign imm_u = {{32{inst[31]}}, inst[31:12], 12'h000};

  // trap reports x10, so read it like any source
  assign regs.rs1_addr = (opcode == op_trap) ? 5'd10 : inst[19:15];
  assign regs.rs2_addr = inst[24:20];

  always_comb begin
    d = '0;
    d.pc = in_data.pc;
    d.alu_op = alu_add;
    d.a = regs.rs1_data;
    d.b = regs.rs2_data;
    d.store_data = regs.rs2_data;
    d.rd = rd;
    d.branch_off = imm_b;
    use_rs1 = 1'b1;
    use_rs2 = 1'b0;
    case (opcode)
      op_op: begin
        use_rs2 = 1'b1;
        d.we = 1'b1;
        if (funct3 != 3'd0 || (inst[31:25] != 7'h00 && inst[31:25] != 7'h20)) d.illegal = 1'b1;
        if (inst[30]) d.alu_op = alu_sub;
      end
      op_imm: begin
        d.b = imm_i;
        d.we = 1'b1;
        d.illegal = (funct3 != 3'd0);
      end
      op_lui: begin
        use_rs1 = 1'b0;
        d.alu_op = alu_pass_b;
        d.b = imm_u;
        d.we = 1'b1;
      end
      op_load: begin
        d.b = imm_i;
        d.load = 1'b1;
        d.we = 1'b1;
        d.illegal = (funct3 != 3'd3);
      end
      op_store: begin
        use_rs2 = 1'b1;
        d.b = imm_s;
        d.store = 1'b1;
        d.illegal = (funct3 != 3'd3);
      end
      op_branch: begin
        use_rs2 = 1'b1;
        d.alu_op = funct3[0] ? alu_bne : alu_beq;
        d.illegal = (funct3[2:1] != 2'b00);
      end
      op_trap: begin
        // x10 + 0 carries the exit code down
        d.b = '0;
        d.trap = 1'b1;
      end
      default: begin
        use_rs1 = 1'b0;
        d.illegal = 1'b1;
      end
    endcase
    d.we = d.we && !d.illegal && (rd != 5'd0);
  end

  // wait on pending sources, and on a pending rd so writes stay ordered
  assign stall = (use_rs1 && pending[regs.rs1_addr]) ||
                 (use_rs2 && pending[regs.rs2_addr]) ||
                 (d.we && pending[rd]);

  assign out_valid = in_valid && !stall;
  assign in_ready = out_ready && !stall;
  assign out_data = d;

  always_ff @(posedge clock) begin
    if (reset) begin
      pending <= '0;
    end else begin
      if (regs.wr_en) pending[regs.wr_addr] <= 1'b0;
      // an issue squashed by a redirect never reaches writeback
      if (out_valid && out_ready && !flush && d.we) pending[rd] <= 1'b1;
    end
  end

endmodule

//--- src/execute_unit.sv
`timescale 1ns/1ps

module execute_unit (
  input  logic                      in_valid,
  output logic                      in_ready,
  input  core_pkg::decoded_t        in_data,
  output logic                      out_valid,
  input  logic                      out_ready,
  output core_pkg::exec_t           out_data,
  output logic                      redirect,
  output logic [core_pkg::xlen-1:0] redirect_pc
);
  import core_pkg::*;

  logic [xlen-1:0] result;
  logic taken;

  assign out_valid = in_valid;
  assign in_ready = out_ready;

  // loads and stores use the add path for the address
  always_comb begin
    case (in_data.alu_op)
      alu_add: result = in_data.a + in_data.b;
      alu_sub: result = in_data.a - in_data.b;
      alu_pass_b: result = in_data.b;
      default: result = '0;
    endcase
  end

  assign taken = (in_data.alu_op == alu_beq && in_data.a == in_data.b) ||
                 (in_data.alu_op == alu_bne && in_data.a != in_data.b);

  // only on the cycle the branch actually moves on
  assign redirect = in_valid && out_ready && taken;
  assign redirect_pc = in_data.pc + in_data.branch_off;

  always_comb begin
    out_data.result = result;
    out_data.store_data = in_data.store_data;
    out_data.rd = in_data.rd;
    out_data.we = in_data.we;
    out_data.load = in_data.load;
    out_data.store = in_data.store;
    out_data.trap = in_data.trap;
    out_data.illegal = in_data.illegal;
  end

endmodule

//--- src/mem_wb_unit.sv
`timescale 1ns/1ps

module mem_wb_unit (
  input  logic                      clock,
  input  logic                      reset,
  input  logic                      in_valid,
  output logic                      in_ready,
  input  core_pkg::exec_t           in_data,
  output logic                      mem_rw_valid,
  input  logic                      mem_rw_ready,
  output logic                      mem_rw_req,
  input  logic [core_pkg::xlen-1:0] mem_r_data,
  output logic [core_pkg::xlen-1:0] mem_w_data,
  output logic [core_pkg::xlen-1:0] mem_rw_addr,
  output logic [1:0]                mem_rw_size,
  input  logic [1:0]                mem_rw_resp,
  reg_port_if.writeback             regs,
  output logic                      halted,
  output logic [7:0]                halt_code
);
  import core_pkg::*;

  typedef enum logic [1:0] {s_idle, s_access, s_halted} state_t;

  state_t state;
  exec_t cur;
  logic take;

  assign in_ready = (state == s_idle);
  assign take = in_valid && in_ready;
  assign halted = (state == s_halted);

  assign mem_rw_valid = (state == s_access);
  assign mem_rw_req = cur.store;
  assign mem_rw_addr = cur.result;
  assign mem_w_data = cur.store_data;
  assign mem_rw_size = size_double;

  // alu results retire on entry, load data on a clean response
  always_comb begin
    regs.wr_en = take && in_data.we && !in_data.load;
    regs.wr_addr = in_data.rd;
    regs.wr_data = in_data.result;
    if (state == s_access) begin
      regs.wr_en = mem_rw_ready && mem_rw_resp == 2'b00 && cur.load && cur.we;
      regs.wr_addr = cur.rd;
      regs.wr_data = mem_r_data;
    end
  end

  always_ff @(posedge clock) begin
    if (take) cur <= in_data;
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      state <= s_idle;
      halt_code <= 8'h00;
    end else begin
      case (state)
        s_idle: begin
          if (take && in_data.trap) begin
            state <= s_halted;
            halt_code <= in_data.result[7:0];
          end else if (take && in_data.illegal) begin
            state <= s_halted;
            halt_code <= halt_illegal;
          end else if (take && (in_data.load || in_data.store)) begin
            state <= s_access;
          end
        end
        s_access: begin
          if (mem_rw_ready && mem_rw_resp != 2'b00) begin
            state <= s_halted;
            halt_code <= halt_bus_error;
          end else if (mem_rw_ready) begin
            state <= s_idle;
          end
        end
        default: state <= s_halted;
      endcase
    end
  end

  a_quiet_halt: assert property (@(posedge clock) disable iff (reset)
    halted |=> halted && !mem_rw_valid);

endmodule

//--- src/reg_file.sv
`timescale 1ns/1ps

module reg_file (
  input logic      clock,
  input logic      reset,
  reg_port_if.file regs
);
  import core_pkg::*;

  logic [xlen-1:0] x [32];

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < 32; i++) begin
        x[i] <= '0;
      end
    end else if (regs.wr_en && regs.wr_addr != 5'd0) begin
      x[regs.wr_addr] <= regs.wr_data;
    end
  end

  // x0 is hardwired
  assign regs.rs1_data = (regs.rs1_addr == 5'd0) ? '0 : x[regs.rs1_addr];
  assign regs.rs2_data = (regs.rs2_addr == 5'd0) ? '0 : x[regs.rs2_addr];

endmodule

//--- src/cpu.sv
`timescale 1ns/1ps

module cpu (
  input  logic                      clock,
  input  logic                      reset,
  output logic                      if_rw_valid,
  input  logic                      if_rw_ready,
  input  logic [core_pkg::xlen-1:0] if_r_data,
  output logic [core_pkg::xlen-1:0] if_rw_addr,
  output logic [1:0]                if_rw_size,
  input  logic [1:0]                if_rw_resp,
  output logic                      mem_rw_valid,
  input  logic                      mem_rw_ready,
  output logic                      mem_rw_req,
  input  logic [core_pkg::xlen-1:0] mem_r_data,
  output logic [core_pkg::xlen-1:0] mem_w_data,
  output logic [core_pkg::xlen-1:0] mem_rw_addr,
  output logic [1:0]                mem_rw_size,
  input  logic [1:0]                mem_rw_resp,
  output logic                      halted,
  output logic [7:0]                halt_code
);
  import core_pkg::*;

  logic f_valid, f_ready, fd_valid, fd_ready;
  logic d_valid, d_ready, de_valid, de_ready;
  logic e_valid, e_ready, em_valid, em_ready;
  logic redirect;
  logic [xlen-1:0] redirect_pc;
  fetch_t f_data, fd_data;
  decoded_t d_data, de_data;
  exec_t e_data, em_data;

  reg_port_if regs ();

  fetch_unit fetch_i (
    .clock, .reset,
    .if_rw_valid, .if_rw_ready, .if_r_data, .if_rw_addr, .if_rw_size, .if_rw_resp,
    .redirect, .redirect_pc, .halted,
    .out_valid(f_valid), .out_ready(f_ready), .out_data(f_data)
  );

  pipe_reg #(.payload_t(fetch_t)) fd_reg_i (
    .clock, .reset, .flush(redirect),
    .in_valid(f_valid), .in_ready(f_ready), .in_data(f_data),
    .out_valid(fd_valid), .out_ready(fd_ready), .out_data(fd_data)
  );

  decode_unit decode_i (
    .clock, .reset, .flush(redirect),
    .in_valid(fd_valid), .in_ready(fd_ready), .in_data(fd_data),
    .out_valid(d_valid), .out_ready(d_ready), .out_data(d_data),
    .regs(regs.decode)
  );

  pipe_reg #(.payload_t(decoded_t)) de_reg_i (
    .clock, .reset, .flush(redirect),
    .in_valid(d_valid), .in_ready(d_ready), .in_data(d_data),
    .out_valid(de_valid), .out_ready(de_ready), .out_data(de_data)
  );

  execute_unit execute_i (
    .in_valid(de_valid), .in_ready(de_ready), .in_data(de_data),
    .out_valid(e_valid), .out_ready(e_ready), .out_data(e_data),
    .redirect, .redirect_pc
  );

  // older than any branch in execute, so never flushed
  pipe_reg #(.payload_t(exec_t)) em_reg_i (
    .clock, .reset, .flush(1'b0),
    .in_valid(e_valid), .in_ready(e_ready), .in_data(e_data),
    .out_valid(em_valid), .out_ready(em_ready), .out_data(em_data)
  );

  mem_wb_unit mem_wb_i (
    .clock, .reset,
    .in_valid(em_valid), .in_ready(em_ready), .in_data(em_data),
    .mem_rw_valid, .mem_rw_ready, .mem_rw_req, .mem_r_data, .mem_w_data,
    .mem_rw_addr, .mem_rw_size, .mem_rw_resp,
    .regs(regs.writeback), .halted, .halt_code
  );

  reg_file reg_file_i (
    .clock, .reset,
    .regs(regs.file)
  );

endmodule

//--- test/clock_gen.sv
`timescale 1ns/1ps

module clock_gen (
  output logic clock,
  output logic reset
);

  initial begin
    clock = 1'b0;
    forever #10 clock = ~clock;
  end

  // power-on reset across three rising edges
  initial begin
    reset = 1'b1;
    repeat (3) @(posedge clock);
    @(negedge clock);
    reset = 1'b0;
  end

endmodule

//--- test/cpu_tb.sv
`timescale 1ns/1ps

module cpu_tb;

  localparam int rows = 5;
  localparam int max_cycles = 2000;

  logic clock;
  logic por_reset;
  logic row_reset;
  logic reset;
  logic if_rw_valid;
  logic if_rw_ready = 1'b0;
  logic [63:0] if_r_data = 64'h0;
  logic [63:0] if_rw_addr;
  logic [1:0] if_rw_size;
  logic [1:0] if_rw_resp = 2'b00;
  logic mem_rw_valid;
  logic mem_rw_ready = 1'b0;
  logic mem_rw_req;
  logic [63:0] mem_r_data = 64'h0;
  logic [63:0] mem_w_data;
  logic [63:0] mem_rw_addr;
  logic [1:0] mem_rw_size;
  logic [1:0] mem_rw_resp = 2'b00;
  logic halted;
  logic [7:0] halt_code;

  // one row per program with code, data image, store sequence, halt code and forced error
  logic [31:0] prog [rows][16];
  logic [63:0] init_mem [rows][8];
  logic [63:0] st_addr [rows][4];
  logic [63:0] st_data [rows][4];
  int n_stores [rows];
  logic [7:0] exp_code [rows];
  int err_index [rows];
  int tr;
  int fill;
  int cur_row = 0;
  int errors = 0;

  // memory model state
  logic [31:0] imem [16];
  logic [63:0] dmem [8];
  logic [63:0] seen_addr [$];
  logic [63:0] seen_data [$];
  logic [31:0] rng = 32'h7db1;
  logic i_busy = 1'b0;
  logic d_busy = 1'b0;
  int i_wait = 0;
  int d_wait = 0;
  int accesses = 0;
  int bus_errors = 0;

  assign reset = por_reset || row_reset;

  clock_gen clock_gen_i (.clock, .reset(por_reset));

  cpu cpu_i (
    .clock, .reset,
    .if_rw_valid, .if_rw_ready, .if_r_data, .if_rw_addr, .if_rw_size, .if_rw_resp,
    .mem_rw_valid, .mem_rw_ready, .mem_rw_req, .mem_r_data, .mem_w_data,
    .mem_rw_addr, .mem_rw_size, .mem_rw_resp,
    .halted, .halt_code
  );

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s ^ (s << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // 0 to 3 wait cycles
  function automatic int next_delay();
    rng = xorshift(rng);
    return {30'd0, rng[1:0]};
  endfunction

  // rv64 encodings
  function automatic logic [31:0] addi(input int rd, input int rs1, input int imm);
    return {imm[11:0], rs1[4:0], 3'd0, rd[4:0], 7'h13};
  endfunction

  function automatic logic [31:0] ld(input int rd, input int rs1, input int imm);
    return {imm[11:0], rs1[4:0], 3'd3, rd[4:0], 7'h03};
  endfunction

  function automatic logic [31:0] sd(input int rs2, input int rs1, input int imm);
    return {imm[11:5], rs2[4:0], rs1[4:0], 3'd3, imm[4:0], 7'h23};
  endfunction

  function automatic logic [31:0] lui(input int rd, input int imm);
    return {imm[19:0], rd[4:0], 7'h37};
  endfunction

  function automatic logic [31:0] reg_op(input logic [6:0] f7, input int rd, input int rs1,
                                         input int rs2);
    return {f7, rs2[4:0], rs1[4:0], 3'd0, rd[4:0], 7'h33};
  endfunction

  function automatic logic [31:0] branch(input logic [2:0] f3, input int rs1, input int rs2,
                                         input int imm);
    return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3, imm[4:1], imm[11], 7'h63};
  endfunction

  task automatic start_row(input int r, input logic [7:0] code, input int err);
    int k;
    tr = r;
    fill = 0;
    exp_code[r] = code;
    err_index[r] = err;
    n_stores[r] = 0;
    for (k = 0; k < 16; k++) begin
      prog[r][k] = 32'h0;
    end
    for (k = 0; k < 8; k++) begin
      init_mem[r][k] = 64'(k * 8) * 64'h0123_4567_89ab_cdef ^ 64'h5a5a_5a5a_5a5a_5a5a;
    end
  endtask

  task automatic add_inst(input logic [31:0] inst);
    prog[tr][fill] = inst;
    fill++;
  endtask

  task automatic add_store(input logic [63:0] addr, input logic [63:0] data);
    st_addr[tr][n_stores[tr]] = addr;
    st_data[tr][n_stores[tr]] = data;
    n_stores[tr]++;
  endtask

  task automatic build_table();
    // arithmetic with back-to-back dependencies
    start_row(0, 8'h2a, -1);
    add_inst(addi(1, 0, 100));
    add_inst(lui(2, 32'h12345));
    add_inst(addi(3, 0, -1));
    add_inst(reg_op(7'h00, 4, 3, 1));
    add_inst(reg_op(7'h20, 5, 1, 2));
    add_inst(lui(6, 32'h80000));
    add_inst(sd(4, 0, 0));
    add_inst(sd(5, 0, 8));
    add_inst(sd(2, 0, 16));
    add_inst(sd(6, 0, 24));
    add_inst(addi(10, 0, 32'h12a));
    add_inst(32'h0000_006b);
    add_store(64'd0, 64'hffff_ffff_ffff_ffff + 64'd100);
    add_store(64'd8, 64'd100 - 64'h1234_5000);
    add_store(64'd16, 64'h1234_5000);
    // lui sign-extends bit 31
    add_store(64'd24, 64'hffff_ffff_8000_0000);
    // loads feeding later instructions
    start_row(1, 8'h00, -1);
    init_mem[1][0] = 64'h1122_3344_5566_7788;
    init_mem[1][1] = 64'hdead_beef_00c0_ffee;
    add_inst(ld(1, 0, 8));
    add_inst(addi(2, 1, 1));
    add_inst(sd(2, 0, 16));
    add_inst(ld(3, 0, 0));
    add_inst(sd(3, 0, 24));
    add_inst(32'h0000_006b);
    add_store(64'd16, 64'hdead_beef_00c0_ffee + 64'd1);
    add_store(64'd24, 64'h1122_3344_5566_7788);
    // taken and not-taken branches
    start_row(2, 8'h07, -1);
    add_inst(addi(1, 0, 3));
    add_inst(addi(2, 0, 3));
    add_inst(branch(3'd0, 1, 2, 12));
    add_inst(sd(1, 0, 0));
    add_inst(sd(2, 0, 8));
    add_inst(branch(3'd1, 1, 2, 8));
    add_inst(sd(1, 0, 16));
    add_inst(branch(3'd1, 1, 0, 8));
    add_inst(sd(2, 0, 24));
    add_inst(branch(3'd0, 1, 0, 8));
    add_inst(sd(2, 0, 32));
    add_inst(addi(10, 0, 7));
    add_inst(32'h0000_006b);
    add_store(64'd16, 64'd3);
    add_store(64'd32, 64'd3);
    // unknown opcode stops the core
    start_row(3, 8'hff, -1);
    add_inst(addi(1, 0, 1));
    add_inst(sd(1, 0, 0));
    add_inst(32'h0000_007f);
    add_inst(sd(1, 0, 8));
    add_store(64'd0, 64'd1);
    // error response on the second data access
    start_row(4, 8'hfe, 1);
    add_inst(addi(1, 0, 9));
    add_inst(sd(1, 0, 0));
    add_inst(ld(2, 0, 0));
    add_inst(sd(2, 0, 8));
    add_store(64'd0, 64'd9);
  endtask

  task automatic load_memories();
    int k;
    for (k = 0; k < 16; k++) begin
      imem[k] = prog[cur_row][k];
    end
    for (k = 0; k < 8; k++) begin
      dmem[k] = init_mem[cur_row][k];
    end
    seen_addr.delete();
    seen_data.delete();
    accesses = 0;
  endtask

  task automatic serve_fetch();
    int k;
    if (if_rw_ready) begin
      if_rw_ready = 1'b0;
      i_busy = 1'b0;
    end
    if (if_rw_valid && !i_busy) begin
      i_busy = 1'b1;
      i_wait = next_delay();
      if (if_rw_size !== 2'd2) begin
        $display("Fail if_rw_size expected %h got %h", 2'd2, if_rw_size);
        bus_errors++;
      end
    end
    if (i_busy && i_wait == 0) begin
      k = {28'd0, if_rw_addr[5:3], 1'b0};
      if_r_data = (if_rw_addr < 64'd64) ? {imem[k + 1], imem[k]} : 64'h0;
      if_rw_resp = 2'b00;
      if_rw_ready = 1'b1;
    end else if (i_busy) begin
      i_wait--;
    end
  endtask

  task automatic serve_data();
    int k;
    if (mem_rw_ready) begin
      mem_rw_ready = 1'b0;
      d_busy = 1'b0;
    end
    if (mem_rw_valid && !d_busy) begin
      d_busy = 1'b1;
      d_wait = next_delay();
      if (mem_rw_size !== 2'd3) begin
        $display("Fail mem_rw_size expected %h got %h", 2'd3, mem_rw_size);
        bus_errors++;
      end
    end
    if (d_busy && d_wait == 0) begin
      k = {29'd0, mem_rw_addr[5:3]};
      mem_rw_resp = (accesses == err_index[cur_row]) ? 2'b10 : 2'b00;
      if (mem_rw_resp == 2'b00 && mem_rw_req) begin
        dmem[k] = mem_w_data;
        seen_addr.push_back(mem_rw_addr);
        seen_data.push_back(mem_w_data);
      end
      mem_r_data = dmem[k];
      accesses++;
      mem_rw_ready = 1'b1;
    end else if (d_busy) begin
      d_wait--;
    end
  endtask

  // both buses answer on the falling edge
  always @(negedge clock) begin
    if (reset) begin
      if_rw_ready = 1'b0;
      mem_rw_ready = 1'b0;
      i_busy = 1'b0;
      d_busy = 1'b0;
      load_memories();
    end else begin
      serve_fetch();
      serve_data();
    end
  end

  task automatic run_row(input int r);
    int cycles;
    int k;
    logic prev_i;
    logic prev_d;
    @(negedge clock);
    cur_row = r;
    row_reset = 1'b1;
    repeat (3) @(negedge clock);
    row_reset = 1'b0;
    if (halted !== 1'b0) begin
      $display("Fail halted expected %h got %h", 1'b0, halted);
      errors++;
    end
    // first fetch goes out one cycle after reset with the reset pc
    @(negedge clock);
    if (if_rw_valid !== 1'b1) begin
      $display("Fail if_rw_valid expected %h got %h", 1'b1, if_rw_valid);
      errors++;
    end
    if (if_rw_addr !== 64'h0) begin
      $display("Fail if_rw_addr expected %h got %h", 64'h0, if_rw_addr);
      errors++;
    end
    cycles = 0;
    while (halted !== 1'b1 && cycles < max_cycles) begin
      @(negedge clock);
      cycles++;
    end
    if (halted !== 1'b1) begin
      $display("row %0d: the core did not halt within %0d cycles", r, max_cycles);
      errors++;
      return;
    end
    if (halt_code !== exp_code[r]) begin
      $display("Fail halt_code expected %h got %h", exp_code[r], halt_code);
      errors++;
    end
    // a halted core starts no new bus request
    prev_i = if_rw_valid;
    prev_d = mem_rw_valid;
    repeat (20) begin
      @(negedge clock);
      if (!prev_i && if_rw_valid) begin
        $display("row %0d: instruction request started after the halt", r);
        errors++;
      end
      if (!prev_d && mem_rw_valid) begin
        $display("row %0d: data request started after the halt", r);
        errors++;
      end
      prev_i = if_rw_valid;
      prev_d = mem_rw_valid;
    end
    if (seen_addr.size() != n_stores[r]) begin
      $display("row %0d: expected %0d stores but saw %0d", r, n_stores[r], seen_addr.size());
      errors++;
    end
    for (k = 0; k < n_stores[r] && k < seen_addr.size(); k++) begin
      if (seen_addr[k] !== st_addr[r][k]) begin
        $display("Fail mem_rw_addr expected %h got %h", st_addr[r][k], seen_addr[k]);
        errors++;
      end
      if (seen_data[k] !== st_data[r][k]) begin
        $display("Fail mem_w_data expected %h got %h", st_data[r][k], seen_data[k]);
        errors++;
      end
    end
  endtask

  initial begin
    row_reset = 1'b1;
    build_table();
    for (int r = 0; r < rows; r++) begin
      run_row(r);
    end
    $display("%0d errors over %0d table rows", errors + bus_errors, rows);
    if (errors + bus_errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

//--- src.f
src/core_pkg.sv
src/reg_port_if.sv
src/pipe_reg.sv
src/fetch_unit.sv
src/decode_unit.sv
src/execute_unit.sv
src/mem_wb_unit.sv
src/reg_file.sv
src/cpu.sv
test/clock_gen.sv
test/cpu_tb.sv

//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --assert --top-module cpu_tb -f src.f -o cpu_sim
	./obj_dir/cpu_sim | tee sim.log
	grep -q "All tests passed" sim.log

clean:
	rm -rf obj_dir sim.log
